// File: logic/mul_arch_pkg.sv
package mul_arch_pkg;

    ////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////

    // Operand and result word
    localparam int DATA_WIDTH = 32;

    // Reorder buffer ticket and instruction id
    localparam int ROB_ID_WIDTH = 6;

    localparam int REG_ADDR_WIDTH = 5;
    localparam int PC_WIDTH = 32;

    ////////////////////////////////////////
    // Operand word encodings
    ////////////////////////////////////////

    // Ticket sits in the low bits of the word
    typedef struct packed {
        logic [DATA_WIDTH-ROB_ID_WIDTH-1:0] pad;
        logic [ROB_ID_WIDTH-1:0]            rob_id;
    } rob_ticket_t;

    // The pending flag next to the word tells which view is valid
    typedef union packed {
        logic [DATA_WIDTH-1:0] value;
        rob_ticket_t           ticket;
    } operand_word_u;

endpackage

// File: logic/mul_operand_stage.sv
`timescale 1ns/1ps

module mul_operand_stage
(
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    flush,

    // Request from decode
    input  logic                                    req_valid,
    input  logic [mul_arch_pkg::ROB_ID_WIDTH-1:0]   req_instr_id,
    input  logic [mul_arch_pkg::PC_WIDTH-1:0]       req_pc,
    input  logic [mul_arch_pkg::REG_ADDR_WIDTH-1:0] req_rd_addr,
    input  mul_arch_pkg::operand_word_u             req_src1_word,
    input  logic                                    req_src1_pending,
    input  mul_arch_pkg::operand_word_u             req_src2_word,
    input  logic                                    req_src2_pending,
    input  logic                                    req_xcpt_valid,
    input  mul_xcpt_pkg::xcpt_cause_t               req_xcpt_cause,

    // Reorder buffer query, answered in the same cycle
    output logic [mul_arch_pkg::ROB_ID_WIDTH-1:0]   rob_src1_id,
    output logic [mul_arch_pkg::ROB_ID_WIDTH-1:0]   rob_src2_id,
    input  logic                                    rob_src1_hit,
    input  logic                                    rob_src2_hit,
    input  logic [mul_arch_pkg::DATA_WIDTH-1:0]     rob_src1_data,
    input  logic [mul_arch_pkg::DATA_WIDTH-1:0]     rob_src2_data,

    output logic                                    stall_decode,
    mul_issue_if.source                             issue
);
    import mul_arch_pkg::*;

    // Held copy of a request waiting on the reorder buffer
    logic [ROB_ID_WIDTH-1:0]   held_instr_id;
    logic [PC_WIDTH-1:0]       held_pc;
    logic [REG_ADDR_WIDTH-1:0] held_rd_addr;
    operand_word_u             held_src1_word;
    operand_word_u             held_src2_word;
    logic                      held_src1_pending;
    logic                      held_src2_pending;

    // Hits already seen for the held request
    logic                      src1_found;
    logic                      src2_found;
    logic [DATA_WIDTH-1:0]     src1_captured;
    logic [DATA_WIDTH-1:0]     src2_captured;

    // Request being worked on this cycle
    logic                      accept;
    logic                      active;
    logic                      cur_xcpt;
    logic [ROB_ID_WIDTH-1:0]   cur_instr_id;
    logic [PC_WIDTH-1:0]       cur_pc;
    logic [REG_ADDR_WIDTH-1:0] cur_rd_addr;
    operand_word_u             cur_src1_word;
    operand_word_u             cur_src2_word;
    logic                      cur_src1_pending;
    logic                      cur_src2_pending;
    logic                      src1_ready;
    logic                      src2_ready;
    logic                      resolve;
    logic                      stall_next;
    logic [DATA_WIDTH-1:0]     operand_a;
    logic [DATA_WIDTH-1:0]     operand_b;

    ////////////////////////////////////////
    // Operand resolution
    ////////////////////////////////////////

    always_comb
    begin
        accept   = req_valid & ~stall_decode;
        active   = accept | stall_decode;
        // Held requests never carry an exception
        cur_xcpt = accept & req_xcpt_valid;

        if (stall_decode)
        begin
            cur_instr_id     = held_instr_id;
            cur_pc           = held_pc;
            cur_rd_addr      = held_rd_addr;
            cur_src1_word    = held_src1_word;
            cur_src2_word    = held_src2_word;
            cur_src1_pending = held_src1_pending;
            cur_src2_pending = held_src2_pending;
        end
        else
        begin
            cur_instr_id     = req_instr_id;
            cur_pc           = req_pc;
            cur_rd_addr      = req_rd_addr;
            cur_src1_word    = req_src1_word;
            cur_src2_word    = req_src2_word;
            cur_src1_pending = req_src1_pending;
            cur_src2_pending = req_src2_pending;
        end

        rob_src1_id = cur_src1_word.ticket.rob_id;
        rob_src2_id = cur_src2_word.ticket.rob_id;

        src1_ready = ~cur_src1_pending | src1_found | rob_src1_hit;
        src2_ready = ~cur_src2_pending | src2_found | rob_src2_hit;

        resolve    = active & (cur_xcpt | (src1_ready & src2_ready));
        stall_next = active & ~resolve;

        // Captured hit first, then this cycle's hit
        operand_a = ~cur_src1_pending ? cur_src1_word.value :
                    src1_found        ? src1_captured : rob_src1_data;
        operand_b = ~cur_src2_pending ? cur_src2_word.value :
                    src2_found        ? src2_captured : rob_src2_data;
    end

    ////////////////////////////////////////
    // Stall and issue registers
    ////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset | flush)
        begin
            stall_decode <= 1'b0;
            src1_found   <= 1'b0;
            src2_found   <= 1'b0;
            issue.valid  <= 1'b0;
        end
        else
        begin
            stall_decode <= stall_next;
            src1_found   <= stall_next & cur_src1_pending & (src1_found | rob_src1_hit);
            src2_found   <= stall_next & cur_src2_pending & (src2_found | rob_src2_hit);
            issue.valid  <= resolve;
        end
    end

    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            held_instr_id     <= req_instr_id;
            held_pc           <= req_pc;
            held_rd_addr      <= req_rd_addr;
            held_src1_word    <= req_src1_word;
            held_src2_word    <= req_src2_word;
            held_src1_pending <= req_src1_pending;
            held_src2_pending <= req_src2_pending;
        end

        // Keep the first hit of each source
        if (active & cur_src1_pending & ~src1_found & rob_src1_hit)
            src1_captured <= rob_src1_data;
        if (active & cur_src2_pending & ~src2_found & rob_src2_hit)
            src2_captured <= rob_src2_data;

        if (resolve)
        begin
            issue.instr_id   <= cur_instr_id;
            issue.pc         <= cur_pc;
            issue.rd_addr    <= cur_rd_addr;
            issue.operand_a  <= operand_a;
            issue.operand_b  <= operand_b;
            issue.xcpt_valid <= cur_xcpt;
            issue.xcpt_cause <= req_xcpt_cause;
        end
    end

endmodule

// File: logic/mul_product_pipe.sv
`timescale 1ns/1ps

module mul_product_pipe
#(
    parameter int MUL_STAGES = 3
)
(
    input  logic          clock,
    input  logic          reset,
    input  logic          flush,
    mul_issue_if.sink     issue,
    mul_result_if.source  result
);
    import mul_arch_pkg::*;
    import mul_xcpt_pkg::*;

    // Unsigned double-width product of the issued operands
    logic [2*DATA_WIDTH-1:0]   full_product;

    // One slot per multiply stage
    logic [MUL_STAGES-1:0]     valid_q;
    logic [ROB_ID_WIDTH-1:0]   instr_id_q   [MUL_STAGES];
    logic [PC_WIDTH-1:0]       pc_q         [MUL_STAGES];
    logic [REG_ADDR_WIDTH-1:0] rd_addr_q    [MUL_STAGES];
    logic [2*DATA_WIDTH-1:0]   product_q    [MUL_STAGES];
    logic                      xcpt_valid_q [MUL_STAGES];
    xcpt_cause_t               xcpt_cause_q [MUL_STAGES];

    assign full_product = (2*DATA_WIDTH)'(issue.operand_a) * (2*DATA_WIDTH)'(issue.operand_b);

    always_ff @(posedge clock)
    begin
        if (reset | flush)
            valid_q <= '0;
        else
        begin
            valid_q[0] <= issue.valid;
            for (int i = 1; i < MUL_STAGES; i++)
                valid_q[i] <= valid_q[i-1];
        end
    end

    always_ff @(posedge clock)
    begin
        instr_id_q[0]   <= issue.instr_id;
        pc_q[0]         <= issue.pc;
        rd_addr_q[0]    <= issue.rd_addr;
        product_q[0]    <= full_product;
        xcpt_valid_q[0] <= issue.xcpt_valid;
        xcpt_cause_q[0] <= issue.xcpt_cause;

        for (int i = 1; i < MUL_STAGES; i++)
        begin
            instr_id_q[i]   <= instr_id_q[i-1];
            pc_q[i]         <= pc_q[i-1];
            rd_addr_q[i]    <= rd_addr_q[i-1];
            product_q[i]    <= product_q[i-1];
            xcpt_valid_q[i] <= xcpt_valid_q[i-1];
            xcpt_cause_q[i] <= xcpt_cause_q[i-1];
        end
    end

    // Last slot feeds writeback
    assign result.valid      = valid_q[MUL_STAGES-1];
    assign result.instr_id   = instr_id_q[MUL_STAGES-1];
    assign result.pc         = pc_q[MUL_STAGES-1];
    assign result.rd_addr    = rd_addr_q[MUL_STAGES-1];
    assign result.product    = product_q[MUL_STAGES-1];
    assign result.xcpt_valid = xcpt_valid_q[MUL_STAGES-1];
    assign result.xcpt_cause = xcpt_cause_q[MUL_STAGES-1];

endmodule

// File: logic/mul_stage_if.sv
`timescale 1ns/1ps

// Resolved operands, operand stage to product pipe
interface mul_issue_if;
    import mul_arch_pkg::*;
    import mul_xcpt_pkg::*;

    logic                      valid;
    logic [ROB_ID_WIDTH-1:0]   instr_id;
    logic [PC_WIDTH-1:0]       pc;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [DATA_WIDTH-1:0]     operand_a;
    logic [DATA_WIDTH-1:0]     operand_b;
    logic                      xcpt_valid;
    xcpt_cause_t               xcpt_cause;

    modport source (output valid, instr_id, pc, rd_addr, operand_a, operand_b,
                    xcpt_valid, xcpt_cause);
    modport sink (input valid, instr_id, pc, rd_addr, operand_a, operand_b,
                  xcpt_valid, xcpt_cause);
endinterface

// Full product, product pipe to writeback stage
interface mul_result_if;
    import mul_arch_pkg::*;
    import mul_xcpt_pkg::*;

    logic                      valid;
    logic [ROB_ID_WIDTH-1:0]   instr_id;
    logic [PC_WIDTH-1:0]       pc;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [2*DATA_WIDTH-1:0]   product;
    logic                      xcpt_valid;
    xcpt_cause_t               xcpt_cause;

    modport source (output valid, instr_id, pc, rd_addr, product,
                    xcpt_valid, xcpt_cause);
    modport sink (input valid, instr_id, pc, rd_addr, product,
                  xcpt_valid, xcpt_cause);
endinterface

// File: logic/mul_top.sv
`timescale 1ns/1ps

module mul_top
#(
    parameter int MUL_STAGES = 3
)
(
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    flush,

    // Request from decode
    input  logic                                    req_valid,
    input  logic [mul_arch_pkg::ROB_ID_WIDTH-1:0]   req_instr_id,
    input  logic [mul_arch_pkg::PC_WIDTH-1:0]       req_pc,
    input  logic [mul_arch_pkg::REG_ADDR_WIDTH-1:0] req_rd_addr,
    input  mul_arch_pkg::operand_word_u             req_src1_word,
    input  logic                                    req_src1_pending,
    input  mul_arch_pkg::operand_word_u             req_src2_word,
    input  logic                                    req_src2_pending,
    input  logic                                    req_xcpt_valid,
    input  mul_xcpt_pkg::xcpt_cause_t               req_xcpt_cause,
    output logic                                    stall_decode,

    // Reorder buffer bypass
    output logic [mul_arch_pkg::ROB_ID_WIDTH-1:0]   rob_src1_id,
    output logic [mul_arch_pkg::ROB_ID_WIDTH-1:0]   rob_src2_id,
    input  logic                                    rob_src1_hit,
    input  logic                                    rob_src2_hit,
    input  logic [mul_arch_pkg::DATA_WIDTH-1:0]     rob_src1_data,
    input  logic [mul_arch_pkg::DATA_WIDTH-1:0]     rob_src2_data,

    // Writeback request
    output logic                                    wb_valid,
    output logic [mul_arch_pkg::ROB_ID_WIDTH-1:0]   wb_instr_id,
    output logic [mul_arch_pkg::PC_WIDTH-1:0]       wb_pc,
    output logic [mul_arch_pkg::REG_ADDR_WIDTH-1:0] wb_rd_addr,
    output logic [mul_arch_pkg::DATA_WIDTH-1:0]     wb_data,
    output logic                                    wb_xcpt_valid,
    output mul_xcpt_pkg::xcpt_cause_t               wb_xcpt_cause
);

    mul_issue_if  issue_bus ();
    mul_result_if result_bus ();

    mul_operand_stage u_operand_stage
    (
        .clock            (clock),
        .reset            (reset),
        .flush            (flush),
        .req_valid        (req_valid),
        .req_instr_id     (req_instr_id),
        .req_pc           (req_pc),
        .req_rd_addr      (req_rd_addr),
        .req_src1_word    (req_src1_word),
        .req_src1_pending (req_src1_pending),
        .req_src2_word    (req_src2_word),
        .req_src2_pending (req_src2_pending),
        .req_xcpt_valid   (req_xcpt_valid),
        .req_xcpt_cause   (req_xcpt_cause),
        .rob_src1_id      (rob_src1_id),
        .rob_src2_id      (rob_src2_id),
        .rob_src1_hit     (rob_src1_hit),
        .rob_src2_hit     (rob_src2_hit),
        .rob_src1_data    (rob_src1_data),
        .rob_src2_data    (rob_src2_data),
        .stall_decode     (stall_decode),
        .issue            (issue_bus.source)
    );

    mul_product_pipe #(
        .MUL_STAGES (MUL_STAGES)
    ) u_product_pipe (
        .clock  (clock),
        .reset  (reset),
        .flush  (flush),
        .issue  (issue_bus.sink),
        .result (result_bus.source)
    );

    mul_writeback_stage u_writeback_stage
    (
        .clock         (clock),
        .reset         (reset),
        .flush         (flush),
        .result        (result_bus.sink),
        .wb_valid      (wb_valid),
        .wb_instr_id   (wb_instr_id),
        .wb_pc         (wb_pc),
        .wb_rd_addr    (wb_rd_addr),
        .wb_data       (wb_data),
        .wb_xcpt_valid (wb_xcpt_valid),
        .wb_xcpt_cause (wb_xcpt_cause)
    );

endmodule

// File: logic/mul_writeback_stage.sv
`timescale 1ns/1ps

module mul_writeback_stage
(
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    flush,
    mul_result_if.sink                              result,

    // Writeback request
    output logic                                    wb_valid,
    output logic [mul_arch_pkg::ROB_ID_WIDTH-1:0]   wb_instr_id,
    output logic [mul_arch_pkg::PC_WIDTH-1:0]       wb_pc,
    output logic [mul_arch_pkg::REG_ADDR_WIDTH-1:0] wb_rd_addr,
    output logic [mul_arch_pkg::DATA_WIDTH-1:0]     wb_data,
    output logic                                    wb_xcpt_valid,
    output mul_xcpt_pkg::xcpt_cause_t               wb_xcpt_cause
);
    import mul_arch_pkg::*;
    import mul_xcpt_pkg::*;

    logic        overflow;
    logic        xcpt_next;
    xcpt_cause_t cause_next;
    logic        wb_valid_q;
    logic        wb_xcpt_q;

    // Upper half set means the result does not fit in one word
    assign overflow  = |result.product[2*DATA_WIDTH-1:DATA_WIDTH];
    assign xcpt_next = result.xcpt_valid | overflow;

    // Incoming exception wins over overflow
    assign cause_next = result.xcpt_valid ? result.xcpt_cause :
                        overflow          ? XCPT_OVERFLOW : XCPT_NONE;

    always_ff @(posedge clock)
    begin
        if (reset | flush)
            wb_valid_q <= 1'b0;
        else
            wb_valid_q <= result.valid;
    end

    always_ff @(posedge clock)
    begin
        wb_instr_id   <= result.instr_id;
        wb_pc         <= result.pc;
        wb_rd_addr    <= result.rd_addr;
        wb_data       <= result.product[DATA_WIDTH-1:0];
        wb_xcpt_q     <= xcpt_next;
        wb_xcpt_cause <= cause_next;
    end

    // Nothing leaves during a flush cycle
    assign wb_valid      = wb_valid_q & ~flush;
    assign wb_xcpt_valid = wb_valid & wb_xcpt_q;

endmodule

// File: logic/mul_xcpt_pkg.sv
package mul_xcpt_pkg;

    // Exception causes carried down to writeback
    typedef enum logic [2:0] {
        XCPT_NONE          = 3'd0,
        XCPT_ITLB_MISS     = 3'd1,
        XCPT_BUS_ERROR     = 3'd2,
        XCPT_ILLEGAL_INSTR = 3'd3,
        // Raised by the multiplier itself
        XCPT_OVERFLOW      = 3'd4
    } xcpt_cause_t;

endpackage

// File: mul_top.f
logic/mul_arch_pkg.sv
logic/mul_xcpt_pkg.sv
logic/mul_stage_if.sv
logic/mul_operand_stage.sv
logic/mul_product_pipe.sv
logic/mul_writeback_stage.sv
logic/mul_top.sv
tb/mul_clock_gen.sv
tb/mul_tb_sva.sv
tb/mul_tb.sv

// File: tb/mul_clock_gen.sv
`timescale 1ns/1ps

module mul_clock_gen
#(
    parameter real PERIOD_NS = 4.0
)
(
    output logic clock
);

    initial
    begin
        clock = 1'b0;
        forever
            #(PERIOD_NS / 2.0) clock = ~clock;
    end

endmodule

// File: tb/mul_tb.sv
`timescale 1ns/1ps

module mul_tb;
    import mul_arch_pkg::*;
    import mul_xcpt_pkg::*;

    localparam int MUL_STAGES   = 3;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 1;

    typedef struct {
        logic [DATA_WIDTH-1:0]   a;
        logic [DATA_WIDTH-1:0]   b;
        logic                    src1_pending;
        logic                    src2_pending;
        logic [ROB_ID_WIDTH-1:0] src1_ticket;
        logic [ROB_ID_WIDTH-1:0] src2_ticket;
        int                      src1_delay;
        int                      src2_delay;
        logic                    xcpt_valid;
        xcpt_cause_t             xcpt_cause;
        logic                    flush_at_resolve;
    } row_t;

    typedef struct {
        int                        due;
        logic [ROB_ID_WIDTH-1:0]   instr_id;
        logic [PC_WIDTH-1:0]       pc;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic [DATA_WIDTH-1:0]     data;
        logic                      data_known;
        logic                      xcpt_valid;
        xcpt_cause_t               xcpt_cause;
    } expect_t;

    logic                      clock;
    logic                      reset;
    logic                      flush;
    logic                      req_valid;
    logic [ROB_ID_WIDTH-1:0]   req_instr_id;
    logic [PC_WIDTH-1:0]       req_pc;
    logic [REG_ADDR_WIDTH-1:0] req_rd_addr;
    operand_word_u             req_src1_word;
    operand_word_u             req_src2_word;
    logic                      req_src1_pending;
    logic                      req_src2_pending;
    logic                      req_xcpt_valid;
    xcpt_cause_t               req_xcpt_cause;
    logic                      stall_decode;
    logic [ROB_ID_WIDTH-1:0]   rob_src1_id;
    logic [ROB_ID_WIDTH-1:0]   rob_src2_id;
    logic                      rob_src1_hit;
    logic                      rob_src2_hit;
    logic [DATA_WIDTH-1:0]     rob_src1_data;
    logic [DATA_WIDTH-1:0]     rob_src2_data;
    logic                      wb_valid;
    logic [ROB_ID_WIDTH-1:0]   wb_instr_id;
    logic [PC_WIDTH-1:0]       wb_pc;
    logic [REG_ADDR_WIDTH-1:0] wb_rd_addr;
    logic [DATA_WIDTH-1:0]     wb_data;
    logic                      wb_xcpt_valid;
    xcpt_cause_t               wb_xcpt_cause;

    row_t    rows[$];
    expect_t expect_q[$];
    expect_t wb_item;
    row_t    rob_row;
    logic    rob_active;
    int      rob_wait;
    int      cycle_count = 0;
    int      cycle_limit = 0;
    integer  seed;

    mul_clock_gen #(.PERIOD_NS (4.0)) u_clock_gen (.clock (clock));

    mul_top #(.MUL_STAGES (MUL_STAGES)) u_dut (.*);

    always @(posedge clock)
        cycle_count <= cycle_count + 1;

    // Reorder buffer answers only in the cycle the row's delay runs out
    always_comb
    begin
        rob_src1_hit  = rob_active && rob_wait == rob_row.src1_delay
                        && rob_src1_id == rob_row.src1_ticket;
        rob_src2_hit  = rob_active && rob_wait == rob_row.src2_delay
                        && rob_src2_id == rob_row.src2_ticket;
        rob_src1_data = !rob_active ? '0 : rob_src1_hit ? rob_row.a : ~rob_row.a;
        rob_src2_data = !rob_active ? '0 : rob_src2_hit ? rob_row.b : ~rob_row.b;
    end

    ////////////////////////////////////////
    // Checking
    ////////////////////////////////////////

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want)
        else report_fail($sformatf("error %s got %h expected %h", name, got, want));
    endtask

    always @(posedge clock)
    begin
        if (cycle_limit > 0 && cycle_count > cycle_limit)
            report_fail($sformatf("Run did not finish within %0d cycles", cycle_limit));
    end

    // Bound port assertions count their failures
    always @(negedge clock)
    begin
        if (u_dut.u_sva.error_count != 0)
            report_fail("A bound assertion on the DUT ports failed");
    end

    // Outputs are settled at the falling edge
    always @(negedge clock)
    begin
        if (!reset && wb_valid)
        begin
            assert (expect_q.size() > 0)
            else report_fail("Writeback appeared with no instruction outstanding");
            wb_item = expect_q.pop_front();
            check_field("wb_valid cycle", cycle_count, wb_item.due);
            check_field("wb_instr_id", wb_instr_id, wb_item.instr_id);
            check_field("wb_pc", wb_pc, wb_item.pc);
            check_field("wb_rd_addr", wb_rd_addr, wb_item.rd_addr);
            if (wb_item.data_known)
                check_field("wb_data", wb_data, wb_item.data);
            check_field("wb_xcpt_valid", wb_xcpt_valid, wb_item.xcpt_valid);
            check_field("wb_xcpt_cause", wb_xcpt_cause, wb_item.xcpt_cause);
        end
        else if (!reset && expect_q.size() > 0 && expect_q[0].due <= cycle_count)
            report_fail($sformatf("Writeback of instruction %0h never arrived",
                                  expect_q[0].instr_id));
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic step_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
        rob_wait++;
    endtask

    task automatic add_row(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                           input logic p1, input logic p2,
                           input logic [ROB_ID_WIDTH-1:0] t1, input logic [ROB_ID_WIDTH-1:0] t2,
                           input int d1, input int d2,
                           input logic xv, input xcpt_cause_t xc, input logic fl);
        rows.push_back('{a, b, p1, p2, t1, t2, d1, d2, xv, xc, fl});
    endtask

    task automatic build_table();
        // Ready operands
        add_row(32'd3, 32'd5, 0, 0, 0, 0, 0, 0, 0, XCPT_NONE, 0);
        add_row(32'h0000_ffff, 32'h0001_0000, 0, 0, 0, 0, 0, 0, 0, XCPT_NONE, 0);
        add_row($random(seed), $random(seed), 0, 0, 0, 0, 0, 0, 0, XCPT_NONE, 0);
        // Reorder buffer bypass
        add_row(32'd1234, 32'd77, 1, 0, 5, 0, 0, 0, 0, XCPT_NONE, 0);
        add_row(32'd40000, 32'd3, 0, 1, 0, 9, 0, 1, 0, XCPT_NONE, 0);
        add_row(32'h00ab_cdef, 32'h0000_0123, 1, 1, 12, 13, 4, 2, 0, XCPT_NONE, 0);
        add_row($random(seed) & 32'hffff, $random(seed) & 32'hffff, 1, 1, 30, 31, 2, 5, 0,
                XCPT_NONE, 0);
        // Overflow
        add_row(32'h0001_0000, 32'h0001_0000, 0, 0, 0, 0, 0, 0, 0, XCPT_NONE, 0);
        add_row(32'hffff_ffff, 32'd2, 0, 0, 0, 0, 0, 0, 0, XCPT_NONE, 0);
        // Incoming exceptions even with sources that never hit
        add_row(32'h8000_0000, 32'd4, 0, 0, 0, 0, 0, 0, 1, XCPT_BUS_ERROR, 0);
        add_row(32'd6, 32'd7, 1, 1, 20, 21, 99, 99, 1, XCPT_ILLEGAL_INSTR, 0);
        add_row(32'd9, 32'd9, 0, 0, 0, 0, 0, 0, 1, XCPT_ITLB_MISS, 0);
        // Flush with two instructions in flight after a long stall drains older ones
        add_row(32'd11, 32'd12, 1, 0, 33, 0, 8, 0, 0, XCPT_NONE, 0);
        add_row(32'd13, 32'd14, 0, 0, 0, 0, 0, 0, 0, XCPT_NONE, 0);
        add_row(32'd15, 32'd16, 0, 0, 0, 0, 0, 0, 0, XCPT_NONE, 1);
        add_row(32'd17, 32'd18, 0, 0, 0, 0, 0, 0, 0, XCPT_NONE, 0);
        // Flush while waiting on the reorder buffer
        add_row(32'd19, 32'd20, 1, 0, 40, 0, 6, 0, 0, XCPT_NONE, 1);
        add_row(32'd21, 32'd22, 0, 0, 0, 0, 0, 0, 0, XCPT_NONE, 0);
        // Back to back
        for (int i = 0; i < 4; i++)
            add_row($random(seed), $random(seed), 0, 0, 0, 0, 0, 0, 0, XCPT_NONE, 0);
    endtask

    task automatic apply_row(input int idx);
        row_t                    row;
        expect_t                 item;
        int                      resolve_k;
        int                      accept_cycle;
        logic [2*DATA_WIDTH-1:0] product;

        row = rows[idx];
        while (stall_decode)
            step_cycle();

        req_valid        = 1'b1;
        req_instr_id     = ROB_ID_WIDTH'(idx + 1);
        req_pc           = PC_WIDTH'(32'h0000_1000 + 4 * idx);
        req_rd_addr      = REG_ADDR_WIDTH'(idx);
        req_src1_pending = row.src1_pending;
        req_src2_pending = row.src2_pending;
        req_xcpt_valid   = row.xcpt_valid;
        req_xcpt_cause   = row.xcpt_cause;
        req_src1_word.value = row.src1_pending ? ~row.a : row.a;
        req_src2_word.value = row.src2_pending ? ~row.b : row.b;
        // Ticket overlays the low bits and the padding keeps junk
        if (row.src1_pending)
            req_src1_word.ticket.rob_id = row.src1_ticket;
        if (row.src2_pending)
            req_src2_word.ticket.rob_id = row.src2_ticket;

        rob_row      = row;
        rob_wait     = 0;
        rob_active   = 1'b1;
        accept_cycle = cycle_count;

        resolve_k = 0;
        if (!row.xcpt_valid)
        begin
            if (row.src1_pending && row.src1_delay > resolve_k)
                resolve_k = row.src1_delay;
            if (row.src2_pending && row.src2_delay > resolve_k)
                resolve_k = row.src2_delay;
        end

        for (int k = 0; k <= resolve_k; k++)
        begin
            if (row.flush_at_resolve && k == resolve_k)
            begin
                flush = 1'b1;
                expect_q.delete();
            end
            // Query outputs have settled by the falling edge
            @(negedge clock);
            if (k > 0)
                check_field("stall_decode", stall_decode, 1);
            if (row.src1_pending)
                check_field("rob_src1_id", rob_src1_id, row.src1_ticket);
            if (row.src2_pending)
                check_field("rob_src2_id", rob_src2_id, row.src2_ticket);
            step_cycle();
            req_valid = 1'b0;
        end

        flush      = 1'b0;
        rob_active = 1'b0;
        check_field("stall_decode", stall_decode, 0);

        if (!row.flush_at_resolve)
        begin
            product         = {{DATA_WIDTH{1'b0}}, row.a} * {{DATA_WIDTH{1'b0}}, row.b};
            item.due        = accept_cycle + resolve_k + MUL_STAGES + 2;
            item.instr_id   = ROB_ID_WIDTH'(idx + 1);
            item.pc         = PC_WIDTH'(32'h0000_1000 + 4 * idx);
            item.rd_addr    = REG_ADDR_WIDTH'(idx);
            item.data       = product[DATA_WIDTH-1:0];
            // Unresolved sources leave the product undefined
            item.data_known = !(row.xcpt_valid && (row.src1_pending || row.src2_pending));
            item.xcpt_valid = row.xcpt_valid || (product[2*DATA_WIDTH-1:DATA_WIDTH] != 0);
            item.xcpt_cause = row.xcpt_valid ? row.xcpt_cause :
                              item.xcpt_valid ? XCPT_OVERFLOW : XCPT_NONE;
            expect_q.push_back(item);
        end
    endtask

    initial
    begin
        seed             = 32'he23b_e0e0;
        reset            = 1'b1;
        flush            = 1'b0;
        req_valid        = 1'b0;
        req_instr_id     = '0;
        req_pc           = '0;
        req_rd_addr      = '0;
        req_src1_word    = '0;
        req_src2_word    = '0;
        req_src1_pending = 1'b0;
        req_src2_pending = 1'b0;
        req_xcpt_valid   = 1'b0;
        req_xcpt_cause   = XCPT_NONE;
        rob_active       = 1'b0;
        rob_wait         = 0;

        build_table();
        cycle_limit = RESET_CYCLES + 50;
        foreach (rows[i])
            cycle_limit += rows[i].src1_delay + rows[i].src2_delay + MUL_STAGES + 4;

        repeat (RESET_CYCLES)
            @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        foreach (rows[i])
            apply_row(i);

        while (expect_q.size() > 0)
            step_cycle();
        repeat (MUL_STAGES + 4)
            step_cycle();

        if (u_dut.u_sva.error_count != 0)
            report_fail("A bound assertion on the DUT ports failed");
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: tb/mul_tb_sva.sv
`timescale 1ns/1ps

module mul_tb_sva
(
    input logic clock,
    input logic reset,
    input logic flush,
    input logic req_valid,
    input logic stall_decode,
    input logic wb_valid,
    input logic wb_xcpt_valid
);

    // Failed assertions so far
    int error_count = 0;

    ////////////////////////////////////////
    // Decode side
    ////////////////////////////////////////

    no_req_while_stalled: assert property (@(posedge clock) disable iff (reset)
        !(req_valid && stall_decode))
    else
    begin
        $error("req_valid and stall_decode high in the same cycle");
        error_count++;
    end

    stall_clear_after_reset: assert property (@(posedge clock) reset |=> !stall_decode)
    else
    begin
        $error("stall_decode high in the cycle after reset");
        error_count++;
    end

    stall_clear_after_flush: assert property (@(posedge clock) disable iff (reset)
        flush |=> !stall_decode)
    else
    begin
        $error("stall_decode high in the cycle after flush");
        error_count++;
    end

    ////////////////////////////////////////
    // Writeback side
    ////////////////////////////////////////

    // Registered valid is cleared by the first reset edge
    no_wb_in_reset: assert property (@(posedge clock) reset |=> !wb_valid)
    else
    begin
        $error("wb_valid high while in reset");
        error_count++;
    end

    no_wb_in_flush: assert property (@(posedge clock) disable iff (reset) flush |-> !wb_valid)
    else
    begin
        $error("wb_valid high during a flush cycle");
        error_count++;
    end

    xcpt_needs_valid: assert property (@(posedge clock) disable iff (reset)
        wb_xcpt_valid |-> wb_valid)
    else
    begin
        $error("wb_xcpt_valid high without wb_valid");
        error_count++;
    end

endmodule

bind mul_top mul_tb_sva u_sva
(
    .clock         (clock),
    .reset         (reset),
    .flush         (flush),
    .req_valid     (req_valid),
    .stall_decode  (stall_decode),
    .wb_valid      (wb_valid),
    .wb_xcpt_valid (wb_xcpt_valid)
);
